// File: common/tinyfpu_defs.svh
// sizes for the fp32-in-64-bit tiny fpu; changing them is not supported by the rtl
`ifndef TINYFPU_DEFS_SVH
`define TINYFPU_DEFS_SVH

// architectural register width
`define FPU_WIDTH 64

// single precision value width
`define FP32_WIDTH 32

// operands per request
`define FPU_NUM_OPERANDS 2

// result buffer entries
`define FPU_BUF_DEPTH 2

`endif

// File: common/tinyfpu_pkg.sv
// shared types for the tiny fpu; rnd_mode only selects a sub-operation, nothing is rounded
`include "tinyfpu_defs.svh"

package tinyfpu_pkg;

  // operation groups kept by the slice
  typedef enum logic [1:0] {
    MINMAX   = 2'd0,
    SGNJ     = 2'd1,
    CMP      = 2'd2,
    CLASSIFY = 2'd3
  } operation_e;

  // risc-v rm field, reused as sub-operation select
  typedef enum logic [2:0] {
    RNE = 3'b000,
    RTZ = 3'b001,
    RDN = 3'b010,
    RUP = 3'b011,
    RMM = 3'b100
  } roundmode_e;

  // ieee exception flags, fflags order
  typedef struct packed {
    logic nv;
    logic dz;
    logic of;
    logic uf;
    logic nx;
  } status_t;

  typedef logic [7:0] tag_t;

  // request as seen at the top level
  typedef struct packed {
    logic [`FPU_NUM_OPERANDS-1:0][`FPU_WIDTH-1:0] operands;
    operation_e                                   op;
    roundmode_e                                   rnd_mode;
    tag_t                                         tag;
  } fpu_req_t;

  // request after unboxing, fp32 operands only
  typedef struct packed {
    logic [`FPU_NUM_OPERANDS-1:0][`FP32_WIDTH-1:0] operands;
    operation_e                                    op;
    roundmode_e                                    rnd_mode;
    tag_t                                          tag;
  } fp32_req_t;

  // result with flags and returned tag
  typedef struct packed {
    logic [`FPU_WIDTH-1:0] result;
    status_t               status;
    tag_t                  tag;
  } fpu_rsp_t;

  // quiet nan with only the top mantissa bit set
  localparam logic [`FP32_WIDTH-1:0] CANONICAL_NAN = 32'h7fc00000;

endpackage

// File: hw/fp_operand_prep.sv
// combinational operand preparation; fp32 only, so any operand not nan-boxed becomes the canonical nan
`timescale 1ns/10ps
`include "tinyfpu_defs.svh"

module fp_operand_prep (
  input  tinyfpu_pkg::fpu_req_t  req_i,
  output tinyfpu_pkg::fp32_req_t req_o
);

  import tinyfpu_pkg::*;

  logic [`FPU_NUM_OPERANDS-1:0]                  is_boxed;
  logic [`FPU_NUM_OPERANDS-1:0][`FP32_WIDTH-1:0] operands_unboxed;
  logic [`FPU_NUM_OPERANDS-1:0][`FP32_WIDTH-1:0] operands_sel;

  // upper half must be all ones for a valid fp32 value
  for (genvar i = 0; i < `FPU_NUM_OPERANDS; i++) begin : gen_nanbox_check
    assign is_boxed[i] = &req_i.operands[i][`FPU_WIDTH-1:`FP32_WIDTH];
    assign operands_unboxed[i] = is_boxed[i] ? req_i.operands[i][`FP32_WIDTH-1:0]
                                             : CANONICAL_NAN;
  end

  // keep only the operands each group reads
  always_comb begin : select_operands
    operands_sel = operands_unboxed;
    // single-operand op
    if (req_i.op == CLASSIFY) begin
      operands_sel[1] = '0;
    end
  end

  always_comb begin : build_request
    req_o          = '0;
    req_o.operands = operands_sel;
    req_o.op       = req_i.op;
    req_o.rnd_mode = req_i.rnd_mode;
    req_o.tag      = req_i.tag;
  end

endmodule

// File: hw/fp_result_buffer.sv
// small fifo, first-word visible on data_o; full accepts a write only together with a read
`timescale 1ns/10ps
`include "tinyfpu_defs.svh"

module fp_result_buffer #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     reset_i,
  input  logic     flush_i,
  input  payload_t data_i,
  input  logic     valid_i,
  output logic     ready_o,
  output payload_t data_o,
  output logic     valid_o,
  input  logic     ready_i,
  output logic     busy_o
);

  localparam int unsigned DEPTH = `FPU_BUF_DEPTH;
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  payload_t         mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push;
  logic             pop;

  assign valid_o = (count_q != '0);
  assign ready_o = (count_q != CNT_W'(DEPTH)) | ready_i;
  assign push    = valid_i & ready_o;
  assign pop     = valid_o & ready_i;
  assign data_o  = mem_q[rd_ptr_q];
  assign busy_o  = valid_o;

  always_ff @(posedge clk_i) begin : ctrl_regs
    if (reset_i || flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + CNT_W'(push) - CNT_W'(pop);
    end
  end

  // storage only, valid is tracked by count
  always_ff @(posedge clk_i) begin : storage
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

// File: hw/tinyfpu_top.sv
// fp32 non-computational fpu; two-cycle latency without back-pressure, at most three requests held
`timescale 1ns/10ps

module tinyfpu_top (
  input  logic                  clk_i,
  input  logic                  reset_i,
  // request side
  input  tinyfpu_pkg::fpu_req_t req_i,
  input  logic                  in_valid_i,
  output logic                  in_ready_o,
  input  logic                  flush_i,
  // response side
  output tinyfpu_pkg::fpu_rsp_t rsp_o,
  output logic                  out_valid_o,
  input  logic                  out_ready_i,
  // something still in flight
  output logic                  busy_o
);

  import tinyfpu_pkg::*;

  fp32_req_t prep_req;
  fpu_rsp_t  slice_rsp;
  logic      slice_valid;
  logic      slice_busy;
  logic      buf_ready;
  logic      buf_busy;

  // unbox and select operands, purely combinational
  fp_operand_prep i_operand_prep (
    .req_i       ( req_i       ),
    .req_o       ( prep_req    )
  );

  fp_noncomp i_noncomp (
    .clk_i       ( clk_i       ),
    .reset_i     ( reset_i     ),
    .req_i       ( prep_req    ),
    .in_valid_i  ( in_valid_i  ),
    .in_ready_o  ( in_ready_o  ),
    .flush_i     ( flush_i     ),
    .rsp_o       ( slice_rsp   ),
    .out_valid_o ( slice_valid ),
    .out_ready_i ( buf_ready   ),
    .busy_o      ( slice_busy  )
  );

  // absorbs back-pressure from the consumer
  fp_result_buffer #(
    .payload_t   ( fpu_rsp_t   )
  ) i_result_buffer (
    .clk_i       ( clk_i       ),
    .reset_i     ( reset_i     ),
    .flush_i     ( flush_i     ),
    .data_i      ( slice_rsp   ),
    .valid_i     ( slice_valid ),
    .ready_o     ( buf_ready   ),
    .data_o      ( rsp_o       ),
    .valid_o     ( out_valid_o ),
    .ready_i     ( out_ready_i ),
    .busy_o      ( buf_busy    )
  );

  assign busy_o = slice_busy | buf_busy;

endmodule

// File: noncomp/fp_classify.sv
// fp32 class decoder, combinational; class_mask_o bit 0 is -inf and bit 9 is quiet nan as in fclass
`timescale 1ns/10ps
`include "tinyfpu_defs.svh"

module fp_classify (
  input  logic [`FP32_WIDTH-1:0] value_i,
  output logic                   is_zero_o,
  output logic                   is_subnormal_o,
  output logic                   is_normal_o,
  output logic                   is_inf_o,
  output logic                   is_snan_o,
  output logic                   is_qnan_o,
  output logic                   sign_o,
  output logic [9:0]             class_mask_o
);

  localparam int unsigned EXP_W = 8;
  localparam int unsigned MAN_W = `FP32_WIDTH - EXP_W - 1;

  logic [EXP_W-1:0] exponent;
  logic [MAN_W-1:0] mantissa;
  logic             exp_zero;
  logic             exp_ones;
  logic             man_zero;

  assign sign_o   = value_i[`FP32_WIDTH-1];
  assign exponent = value_i[`FP32_WIDTH-2 -: EXP_W];
  assign mantissa = value_i[MAN_W-1:0];

  assign exp_zero = ~(|exponent);
  assign exp_ones = &exponent;
  assign man_zero = ~(|mantissa);

  assign is_zero_o      = exp_zero & man_zero;
  assign is_subnormal_o = exp_zero & ~man_zero;
  assign is_normal_o    = ~exp_zero & ~exp_ones;
  assign is_inf_o       = exp_ones & man_zero;
  // msb of the mantissa marks a quiet nan
  assign is_qnan_o      = exp_ones & mantissa[MAN_W-1];
  assign is_snan_o      = exp_ones & ~man_zero & ~mantissa[MAN_W-1];

  assign class_mask_o = {is_qnan_o,
                         is_snan_o,
                         ~sign_o & is_inf_o,
                         ~sign_o & is_normal_o,
                         ~sign_o & is_subnormal_o,
                         ~sign_o & is_zero_o,
                         sign_o & is_zero_o,
                         sign_o & is_subnormal_o,
                         sign_o & is_normal_o,
                         sign_o & is_inf_o};

endmodule

// File: noncomp/fp_noncomp.sv
// one-stage fp32 min/max, sign injection, compare and classify; unknown sub-operations give zero and nv
`timescale 1ns/10ps
`include "tinyfpu_defs.svh"

module fp_noncomp (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  tinyfpu_pkg::fp32_req_t req_i,
  input  logic                   in_valid_i,
  output logic                   in_ready_o,
  input  logic                   flush_i,
  output tinyfpu_pkg::fpu_rsp_t  rsp_o,
  output logic                   out_valid_o,
  input  logic                   out_ready_i,
  output logic                   busy_o
);

  import tinyfpu_pkg::*;

  localparam int unsigned BOX_W = `FPU_WIDTH - `FP32_WIDTH;
  localparam int unsigned MAG_W = `FP32_WIDTH - 1;

  logic [`FP32_WIDTH-1:0]       op_a;
  logic [`FP32_WIDTH-1:0]       op_b;
  logic [`FPU_NUM_OPERANDS-1:0] is_zero;
  logic [`FPU_NUM_OPERANDS-1:0] is_snan;
  logic [`FPU_NUM_OPERANDS-1:0] is_qnan;
  logic [`FPU_NUM_OPERANDS-1:0] is_nan;
  logic [`FPU_NUM_OPERANDS-1:0] sign;
  logic [9:0]                   class_mask_a;
  logic                         both_zero;
  logic                         order_lt;
  logic                         cmp_lt;
  logic                         cmp_eq;
  logic [`FP32_WIDTH-1:0]       res32;
  logic                         boxed;
  logic                         bad_mode;
  fpu_rsp_t                     rsp_d;
  fpu_rsp_t                     rsp_q;
  logic                         valid_q;
  logic                         accept;

  assign op_a = req_i.operands[0];
  assign op_b = req_i.operands[1];

  fp_classify i_classify_a (
    .value_i        ( op_a         ),
    .is_zero_o      ( is_zero[0]   ),
    .is_subnormal_o (              ),
    .is_normal_o    (              ),
    .is_inf_o       (              ),
    .is_snan_o      ( is_snan[0]   ),
    .is_qnan_o      ( is_qnan[0]   ),
    .sign_o         ( sign[0]      ),
    .class_mask_o   ( class_mask_a )
  );

  fp_classify i_classify_b (
    .value_i        ( op_b         ),
    .is_zero_o      ( is_zero[1]   ),
    .is_subnormal_o (              ),
    .is_normal_o    (              ),
    .is_inf_o       (              ),
    .is_snan_o      ( is_snan[1]   ),
    .is_qnan_o      ( is_qnan[1]   ),
    .sign_o         ( sign[1]      ),
    .class_mask_o   (              )
  );

  assign is_nan = is_snan | is_qnan;

  // sign-magnitude order, -0 sorts below +0
  always_comb begin : compare
    both_zero = &is_zero;
    if (sign[0] != sign[1]) begin
      order_lt = sign[0];
    end else if (sign[0]) begin
      order_lt = op_b[MAG_W-1:0] < op_a[MAG_W-1:0];
    end else begin
      order_lt = op_a[MAG_W-1:0] < op_b[MAG_W-1:0];
    end
    // zeros of either sign are equal for compares
    cmp_lt = order_lt & ~both_zero & ~(|is_nan);
    cmp_eq = (both_zero | (op_a == op_b)) & ~(|is_nan);
  end

  always_comb begin : compute
    res32    = '0;
    boxed    = 1'b0;
    bad_mode = 1'b0;
    rsp_d    = '0;
    case (req_i.op)
      MINMAX: begin
        boxed           = 1'b1;
        rsp_d.status.nv = |is_snan;
        bad_mode        = (req_i.rnd_mode != RNE) && (req_i.rnd_mode != RTZ);
        if (&is_nan) begin
          res32 = CANONICAL_NAN;
        end else if (is_nan[0]) begin
          res32 = op_b;
        end else if (is_nan[1]) begin
          res32 = op_a;
        end else if (req_i.rnd_mode == RNE) begin
          res32 = order_lt ? op_a : op_b;
        end else begin
          res32 = order_lt ? op_b : op_a;
        end
      end
      SGNJ: begin
        boxed = 1'b1;
        case (req_i.rnd_mode)
          RNE:     res32 = {sign[1], op_a[MAG_W-1:0]};
          RTZ:     res32 = {~sign[1], op_a[MAG_W-1:0]};
          RDN:     res32 = {sign[0] ^ sign[1], op_a[MAG_W-1:0]};
          default: bad_mode = 1'b1;
        endcase
      end
      CMP: begin
        case (req_i.rnd_mode)
          RNE: begin
            res32[0]        = cmp_lt | cmp_eq;
            rsp_d.status.nv = |is_nan;
          end
          RTZ: begin
            res32[0]        = cmp_lt;
            rsp_d.status.nv = |is_nan;
          end
          RDN: begin
            // quiet nans compare silently for equality
            res32[0]        = cmp_eq;
            rsp_d.status.nv = |is_snan;
          end
          default: bad_mode = 1'b1;
        endcase
      end
      default: begin
        res32[9:0] = class_mask_a;
      end
    endcase
    if (bad_mode) begin
      rsp_d.result    = '0;
      rsp_d.status    = '0;
      rsp_d.status.nv = 1'b1;
    end else if (boxed) begin
      rsp_d.result = {{BOX_W{1'b1}}, res32};
    end else begin
      rsp_d.result = {{BOX_W{1'b0}}, res32};
    end
    rsp_d.tag = req_i.tag;
  end

  // accept when empty or being drained this cycle
  assign in_ready_o = ~valid_q | out_ready_i;
  assign accept     = in_valid_i & in_ready_o;

  always_ff @(posedge clk_i) begin : out_valid_reg
    if (reset_i || flush_i) begin
      valid_q <= 1'b0;
    end else if (accept) begin
      valid_q <= 1'b1;
    end else if (out_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin : out_data_reg
    if (accept) begin
      rsp_q <= rsp_d;
    end
  end

  assign rsp_o       = rsp_q;
  assign out_valid_o = valid_q;
  assign busy_o      = valid_q;

endmodule

// File: verif/tinyfpu_asserts.sv
// bound to tinyfpu_top; covers the output handshake, reset and flush only
`timescale 1ns/10ps

module tinyfpu_asserts (
  input logic                  clk_i,
  input logic                  reset_i,
  input logic                  flush_i,
  input tinyfpu_pkg::fpu_rsp_t rsp_i,
  input logic                  out_valid_i,
  input logic                  out_ready_i,
  input logic                  busy_i
);

  int fail_count = 0;

  // response held while the consumer stalls
  a_rsp_stable : assert property (@(posedge clk_i) disable iff (reset_i)
    out_valid_i && !out_ready_i && !flush_i |=> $stable(rsp_i))
    else begin
      $error("rsp_o changed while out_valid_o waited for out_ready_i");
      fail_count++;
    end

  a_reset_empty : assert property (@(posedge clk_i) reset_i |=> !out_valid_i)
    else begin
      $error("out_valid_o high in the cycle after reset");
      fail_count++;
    end

  a_flush_empty : assert property (@(posedge clk_i) disable iff (reset_i)
    flush_i |=> !out_valid_i && !busy_i)
    else begin
      $error("out_valid_o or busy_o high in the cycle after a flush");
      fail_count++;
    end

  a_busy_valid : assert property (@(posedge clk_i) disable iff (reset_i)
    out_valid_i |-> busy_i)
    else begin
      $error("out_valid_o high while busy_o is low");
      fail_count++;
    end

endmodule

bind tinyfpu_top tinyfpu_asserts i_tinyfpu_asserts (
  .clk_i       ( clk_i       ),
  .reset_i     ( reset_i     ),
  .flush_i     ( flush_i     ),
  .rsp_i       ( rsp_o       ),
  .out_valid_i ( out_valid_o ),
  .out_ready_i ( out_ready_i ),
  .busy_i      ( busy_o      )
);

// File: verif/tinyfpu_checker.sv
// samples at the falling edge, so inputs must change only after the rising edge; names up to NAME_CHARS
`timescale 1ns/10ps

module tinyfpu_checker #(
  parameter int NAME_CHARS = 16
) (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    flush_i,
  input  logic                    in_valid_i,
  input  logic                    in_ready_i,
  input  logic                    out_valid_i,
  input  logic                    out_ready_i,
  input  logic                    busy_i,
  input  tinyfpu_pkg::fpu_rsp_t   rsp_i,
  input  logic [8*NAME_CHARS-1:0] exp_name_i,
  input  logic [63:0]             exp_result_i,
  input  logic [4:0]              exp_status_i,
  input  tinyfpu_pkg::tag_t       exp_tag_i,
  output int                      error_count_o,
  output int                      check_count_o,
  output logic                    full_seen_o,
  output int                      pending_o
);

  import tinyfpu_pkg::*;

  typedef struct packed {
    logic [8*NAME_CHARS-1:0] name;
    logic [63:0]             result;
    logic [4:0]              status;
    tag_t                    tag;
  } expect_t;

  expect_t expect_q[$];

  initial begin
    error_count_o = 0;
    check_count_o = 0;
    full_seen_o   = 1'b0;
    pending_o     = 0;
  end

  always @(negedge clk_i) begin : watch
    expect_t exp;
    logic    ready_exp;
    // flush and reset drop everything, no transfer counts
    if (reset_i || flush_i) begin
      expect_q.delete();
    end else begin
      // three held and a stalled consumer close the input
      ready_exp = !(expect_q.size() == 3 && !out_ready_i);
      if (in_ready_i != ready_exp) begin
        $display("in_ready_o is %b with %0d items in flight", in_ready_i, expect_q.size());
        error_count_o++;
      end
      if (busy_i != (expect_q.size() != 0)) begin
        $display("busy_o is %b with %0d items in flight", busy_i, expect_q.size());
        error_count_o++;
      end
      if (!in_ready_i) begin
        full_seen_o = 1'b1;
      end
      if (out_valid_i && out_ready_i) begin
        if (expect_q.size() == 0) begin
          $display("a result came out while no request was in flight");
          error_count_o++;
        end else begin
          exp = expect_q.pop_front();
          check_count_o++;
          if (rsp_i.result !== exp.result) begin
            $display("ERROR %0s: result expected %h actual %h", exp.name, exp.result, rsp_i.result);
            error_count_o++;
          end
          if (rsp_i.status !== exp.status) begin
            $display("ERROR %0s: status expected %h actual %h", exp.name, exp.status, rsp_i.status);
            error_count_o++;
          end
          if (rsp_i.tag !== exp.tag) begin
            $display("ERROR %0s: tag expected %h actual %h", exp.name, exp.tag, rsp_i.tag);
            error_count_o++;
          end
        end
      end
      if (in_valid_i && in_ready_i) begin
        expect_q.push_back({exp_name_i, exp_result_i, exp_status_i, exp_tag_i});
      end
    end
    pending_o = expect_q.size();
  end

endmodule

// File: verif/tinyfpu_tb.sv
// reads verif/tinyfpu_tests.txt from the project root; every wait gives up after TIMEOUT_CYCLES
`timescale 1ns/10ps

module tinyfpu_tb;

  import tinyfpu_pkg::*;

  localparam int TIMEOUT_CYCLES = 200;
  localparam int NAME_CHARS     = 16;

  logic                    clk_i;
  logic                    reset_i;
  logic                    flush_i;
  fpu_req_t                req_i;
  logic                    in_valid_i;
  logic                    in_ready_o;
  fpu_rsp_t                rsp_o;
  logic                    out_valid_o;
  logic                    out_ready_i;
  logic                    busy_o;
  logic                    hold_consumer;
  logic [8*NAME_CHARS-1:0] exp_name;
  logic [63:0]             exp_result;
  logic [4:0]              exp_status;
  int                      stim_errors;
  int                      chk_errors;
  int                      checked;
  int                      pending;
  logic                    full_seen;

  tinyfpu_top i_tinyfpu_top (
    .clk_i       ( clk_i       ),
    .reset_i     ( reset_i     ),
    .req_i       ( req_i       ),
    .in_valid_i  ( in_valid_i  ),
    .in_ready_o  ( in_ready_o  ),
    .flush_i     ( flush_i     ),
    .rsp_o       ( rsp_o       ),
    .out_valid_o ( out_valid_o ),
    .out_ready_i ( out_ready_i ),
    .busy_o      ( busy_o      )
  );

  tinyfpu_checker #(
    .NAME_CHARS    ( NAME_CHARS  )
  ) i_checker (
    .clk_i         ( clk_i       ),
    .reset_i       ( reset_i     ),
    .flush_i       ( flush_i     ),
    .in_valid_i    ( in_valid_i  ),
    .in_ready_i    ( in_ready_o  ),
    .out_valid_i   ( out_valid_o ),
    .out_ready_i   ( out_ready_i ),
    .busy_i        ( busy_o      ),
    .rsp_i         ( rsp_o       ),
    .exp_name_i    ( exp_name    ),
    .exp_result_i  ( exp_result  ),
    .exp_status_i  ( exp_status  ),
    .exp_tag_i     ( req_i.tag   ),
    .error_count_o ( chk_errors  ),
    .check_count_o ( checked     ),
    .full_seen_o   ( full_seen   ),
    .pending_o     ( pending     )
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // consumer stalls about a third of the time unless held
  initial begin : consumer
    logic hold_now;
    void'($urandom(32'h0f9e3b20));
    forever begin
      @(posedge clk_i);
      hold_now = hold_consumer;
      #1;
      out_ready_i = hold_now ? 1'b0 : (($urandom % 3) != 0);
    end
  end

  // called at 1 ns after a rising edge, returns at the same point
  task automatic offer_request(input logic [8*NAME_CHARS-1:0] name);
    int   cycles;
    logic ready_seen;
    cycles     = 0;
    ready_seen = 1'b0;
    in_valid_i = 1'b1;
    while (!ready_seen && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk_i);
      ready_seen = in_ready_o;
      @(posedge clk_i);
      #1;
      cycles++;
    end
    in_valid_i = 1'b0;
    if (!ready_seen) begin
      $display("request %0s was never accepted, in_ready_o stayed low", name);
      stim_errors++;
    end
  endtask

  task automatic wait_drained(input string when_text);
    int   cycles;
    logic done;
    cycles = 0;
    done   = 1'b0;
    while (!done && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk_i);
      #1;
      done = (pending == 0) && !busy_o;
      @(posedge clk_i);
      #1;
      cycles++;
    end
    if (!done) begin
      $display("%0d results still missing %0s", pending, when_text);
      stim_errors++;
    end
  endtask

  task automatic flush_pipeline();
    flush_i = 1'b1;
    @(posedge clk_i);
    #1;
    flush_i = 1'b0;
  endtask

  task automatic set_consumer_hold(input logic hold);
    if (hold) begin
      wait_drained("before holding the consumer");
      hold_consumer = 1'b1;
    end else begin
      // leave the full state visible for a few cycles
      repeat (3) @(posedge clk_i);
      #1;
      hold_consumer = 1'b0;
    end
  endtask

  initial begin : stimulus
    int                      fd;
    int                      n;
    int                      total;
    string                   line;
    logic [7:0]              cmd;
    logic [8*NAME_CHARS-1:0] name;
    logic [63:0]             f_op;
    logic [63:0]             f_mode;
    logic [63:0]             f_a;
    logic [63:0]             f_b;
    logic [63:0]             f_tag;
    logic [63:0]             f_res;
    logic [63:0]             f_st;
    reset_i       = 1'b1;
    flush_i       = 1'b0;
    req_i         = '0;
    in_valid_i    = 1'b0;
    out_ready_i   = 1'b0;
    hold_consumer = 1'b0;
    exp_name      = '0;
    exp_result    = '0;
    exp_status    = '0;
    stim_errors   = 0;
    repeat (2) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    fd = $fopen("verif/tinyfpu_tests.txt", "r");
    if (fd == 0) begin
      $display("could not open verif/tinyfpu_tests.txt");
      stim_errors++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n    = $fgets(line, fd);
        if (line.len() == 0 || line.getc(0) == "#") begin
          continue;
        end
        n = $sscanf(line, "%c %s %h %h %h %h %h %h %h",
                    cmd, name, f_op, f_mode, f_a, f_b, f_tag, f_res, f_st);
        if (n < 3) begin
          continue;
        end
        case (cmd)
          "v": begin
            req_i.operands[0] = f_a;
            req_i.operands[1] = f_b;
            req_i.op          = operation_e'(f_op[1:0]);
            req_i.rnd_mode    = roundmode_e'(f_mode[2:0]);
            req_i.tag         = f_tag[7:0];
            exp_name          = name;
            exp_result        = f_res;
            exp_status        = f_st[4:0];
            offer_request(name);
          end
          "f": flush_pipeline();
          "h": set_consumer_hold(f_op[0]);
          default: begin
            $display("unknown command in line: %0s", line);
            stim_errors++;
          end
        endcase
      end
      $fclose(fd);
    end
    hold_consumer = 1'b0;
    wait_drained("at the end of the run");
    if (!full_seen) begin
      $display("in_ready_o never fell with three items held");
      stim_errors++;
    end
    if (checked == 0) begin
      $display("no result was compared");
      stim_errors++;
    end
    total = chk_errors + stim_errors + i_tinyfpu_top.i_tinyfpu_asserts.fail_count;
    $display("errors: %0d checker, %0d stimulus, %0d assertion, %0d results compared",
             chk_errors, stim_errors, i_tinyfpu_top.i_tinyfpu_asserts.fail_count, checked);
    if (total == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: verif/tinyfpu_tests.txt
# cmd name op mode operand0 operand1 tag result status (status 10 means nv)
# v sends a request, f flushes the pipeline, h 1 holds the consumer and h 0 releases it
v min_norm 0 0 ffffffff3f800000 ffffffffc0000000 01 ffffffffc0000000 00
v max_norm 0 1 ffffffff3f800000 ffffffffc0000000 02 ffffffff3f800000 00
v min_zeros 0 0 ffffffff00000000 ffffffff80000000 03 ffffffff80000000 00
v max_qnan 0 1 ffffffff7fc00000 ffffffff40000000 04 ffffffff40000000 00
v min_snan 0 0 ffffffff3f800000 ffffffff7f800001 05 ffffffff3f800000 10
v max_2nan 0 1 ffffffff7f800001 ffffffff7fc00000 06 ffffffff7fc00000 10
v sgnj_plain 1 0 ffffffff3f800000 ffffffffc0000000 07 ffffffffbf800000 00
v sgnjn_inf 1 1 ffffffff7f800000 ffffffff3f800000 08 ffffffffff800000 00
v sgnjx_nan 1 2 ffffffffffc00000 ffffffffbf800000 09 ffffffff7fc00000 00
v fle_zeros 2 0 ffffffff80000000 ffffffff00000000 0a 0000000000000001 00
v flt_zeros 2 1 ffffffff80000000 ffffffff00000000 0b 0000000000000000 00
v feq_norm 2 2 ffffffffbf800000 ffffffffbf800000 0c 0000000000000001 00
v fle_qnan 2 0 ffffffff7fc00000 ffffffff3f800000 0d 0000000000000000 10
v feq_qnan 2 2 ffffffff7fc00000 ffffffff3f800000 0e 0000000000000000 00
v feq_snan 2 2 ffffffff3f800000 ffffffff7f800001 0f 0000000000000000 10
v cls_ninf 3 0 ffffffffff800000 0000000000000000 10 0000000000000001 00
v cls_nnorm 3 0 ffffffffbf800000 0000000000000000 11 0000000000000002 00
v cls_nsub 3 0 ffffffff80000001 0000000000000000 12 0000000000000004 00
v cls_nzero 3 0 ffffffff80000000 0000000000000000 13 0000000000000008 00
v cls_pzero 3 0 ffffffff00000000 0000000000000000 14 0000000000000010 00
v cls_psub 3 0 ffffffff00000001 0000000000000000 15 0000000000000020 00
v cls_pnorm 3 0 ffffffff3f800000 0000000000000000 16 0000000000000040 00
v cls_pinf 3 0 ffffffff7f800000 0000000000000000 17 0000000000000080 00
v cls_snan 3 0 ffffffff7f800001 0000000000000000 18 0000000000000100 00
v cls_qnan 3 0 ffffffff7fc00000 0000000000000000 19 0000000000000200 00
v cls_unboxed 3 0 000000003f800000 0000000000000000 1a 0000000000000200 00
h hold_on 1
v ord_a 0 1 ffffffff40000000 ffffffff3f800000 20 ffffffff40000000 00
v ord_b 1 1 ffffffff40000000 ffffffff3f800000 21 ffffffffc0000000 00
v ord_c 2 1 ffffffff3f800000 ffffffff40000000 22 0000000000000001 00
h hold_off 0
h hold_on 1
v gone_a 3 0 ffffffff3f800000 0000000000000000 30 0000000000000040 00
v gone_b 3 0 ffffffff00000000 0000000000000000 31 0000000000000010 00
f mid_flush 0
h hold_off 0
v after_a 0 0 ffffffff40000000 ffffffff3f800000 32 ffffffff3f800000 00
v after_b 2 2 ffffffff00000000 ffffffff80000000 33 0000000000000001 00

// File: vlog.f
+incdir+common
common/tinyfpu_pkg.sv
noncomp/fp_classify.sv
noncomp/fp_noncomp.sv
hw/fp_operand_prep.sv
hw/fp_result_buffer.sv
hw/tinyfpu_top.sv
verif/tinyfpu_checker.sv
verif/tinyfpu_asserts.sv
verif/tinyfpu_tb.sv
